// ==== logic/dm_geometry_pkg.sv ====
package dm_geometry_pkg;

    // panel size
    localparam int dm_rows = 8;
    localparam int dm_cols = 8;

    // glyph numbers 0 to 15
    localparam int dm_glyph_bits = 4;

    // row counter wide enough for dm_rows
    typedef logic [$clog2(dm_rows)-1:0] row_idx_t;

    // one row of lit columns, bit 0 is column 0
    typedef logic [dm_cols-1:0] col_bits_t;

    // row lines, active low
    typedef logic [dm_rows-1:0] row_sel_t;

    typedef logic [dm_glyph_bits-1:0] glyph_t;

endpackage

// ==== logic/dm_glyph_pkg.sv ====
package dm_glyph_pkg;

    // glyphs at or above this number are blank
    localparam int dm_glyph_count = 12;

    // shown after reset, before any command
    localparam dm_geometry_pkg::glyph_t dm_blank_glyph = 4'd15;

    // bitmaps indexed [glyph][row]
    localparam dm_geometry_pkg::col_bits_t dm_glyph_table
        [0:dm_glyph_count-1][0:dm_geometry_pkg::dm_rows-1] = '{
        // 0 to 4, blobs growing outward
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
          8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
          8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
          8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000},
        '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100},
        // 5, every dot lit
        '{8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111},
        // 6 to 10, pictures
        '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
          8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011},
        '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
          8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011},
        '{8'b0000_0000, 8'b0011_1000, 8'b0100_0100, 8'b0101_1010,
          8'b0100_1010, 8'b0011_0010, 8'b1100_0100, 8'b0011_1000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0110_0000, 8'b1111_1100,
          8'b0011_1111, 8'b0011_1110, 8'b0001_1100, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0111_1110, 8'b0111_1110, 8'b0010_0100, 8'b0000_0000},
        // 11 has no art yet
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000}
    };

endpackage

// ==== logic/dm_scan_if.sv ====
`timescale 1ns/100ps

interface dm_scan_if;
    import dm_geometry_pkg::*;

    logic     valid;
    row_idx_t row_idx;
    glyph_t   glyph;
    logic     hot;    // red bank follows green
    logic     blank;  // both banks dark for this row

    modport scan (
        output valid,
        output row_idx,
        output glyph,
        output hot,
        output blank
    );

    modport lookup (
        input valid,
        input row_idx,
        input glyph,
        input hot,
        input blank
    );

endinterface

// ==== logic/dm_cmd_capture.sv ====
`timescale 1ns/100ps

module dm_cmd_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  dm_geometry_pkg::glyph_t cmd_glyph,
    input  logic                    cmd_hot,
    input  logic                    commit,
    output logic                    cmd_ack,
    output dm_geometry_pkg::glyph_t held_glyph,
    output logic                    held_hot,
    output logic                    pending
);
    import dm_glyph_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_acked,
        s_release
    } state_t;

    state_t state;
    logic   accept;

    assign accept  = (state == s_idle) && cmd_req;
    assign cmd_ack = (state == s_acked);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= s_idle;
        end
        else
        begin
            case (state)
                s_idle:    if (cmd_req) state <= s_acked;
                s_acked:   if (!cmd_req) state <= s_release;  // ack drops here
                s_release: state <= s_idle;
                default:   state <= s_idle;
            endcase
        end
    end

    // a later command overwrites one not yet shown
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            held_glyph <= dm_blank_glyph;
            held_hot   <= 1'b0;
            pending    <= 1'b0;
        end
        else if (accept)
        begin
            held_glyph <= cmd_glyph;
            held_hot   <= cmd_hot;
            pending    <= 1'b1;
        end
        else if (commit)
        begin
            pending <= 1'b0;
        end
    end

endmodule

// ==== logic/dm_row_scan.sv ====
`timescale 1ns/100ps

module dm_row_scan (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  dm_geometry_pkg::glyph_t held_glyph,
    input  logic                    held_hot,
    input  logic                    pending,
    output logic                    commit,
    dm_scan_if.scan                 slot
);
    import dm_geometry_pkg::*;
    import dm_glyph_pkg::*;

    localparam row_idx_t last_row = row_idx_t'(dm_rows - 1);

    row_idx_t row_idx;
    glyph_t   cur_glyph;
    logic     cur_hot;
    logic     started;   // low for the first cycle out of reset

    // swap glyphs only between frames
    assign commit = pending && (row_idx == last_row);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx   <= '0;
            cur_glyph <= dm_blank_glyph;
            cur_hot   <= 1'b0;
            started   <= 1'b0;
        end
        else
        begin
            started <= 1'b1;
            if (row_idx == last_row)
                row_idx <= '0;
            else
                row_idx <= row_idx + row_idx_t'(1);
            if (commit)
            begin
                cur_glyph <= held_glyph;
                cur_hot   <= held_hot;
            end
        end
    end

    assign slot.valid   = started;
    assign slot.row_idx = row_idx;
    assign slot.glyph   = cur_glyph;
    assign slot.hot     = cur_hot;
    assign slot.blank   = !enable;

endmodule

// ==== logic/dm_glyph_stage.sv ====
`timescale 1ns/100ps

module dm_glyph_stage (
    input  logic                       clk,
    input  logic                       rst,
    dm_scan_if.lookup                  slot,
    output dm_geometry_pkg::row_sel_t  row,
    output dm_geometry_pkg::col_bits_t col_green,
    output dm_geometry_pkg::col_bits_t col_red
);
    import dm_geometry_pkg::*;
    import dm_glyph_pkg::*;

    col_bits_t glyph_bits;
    col_bits_t green_next;

    // numbers past the table are blank
    always_comb
    begin
        if (int'(slot.glyph) < dm_glyph_count)
            glyph_bits = dm_glyph_table[slot.glyph][slot.row_idx];
        else
            glyph_bits = '0;
    end

    assign green_next = slot.blank ? '0 : glyph_bits;

    // row select and columns move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row       <= '1;
            col_green <= '0;
            col_red   <= '0;
        end
        else if (!slot.valid)
        begin
            row       <= '1;  // all rows off
            col_green <= '0;
            col_red   <= '0;
        end
        else
        begin
            row       <= ~(row_sel_t'(1) << slot.row_idx);
            col_green <= green_next;
            col_red   <= slot.hot ? green_next : '0;  // green plus red reads as hot
        end
    end

endmodule

// ==== logic/dm_matrix_top.sv ====
`timescale 1ns/100ps

module dm_matrix_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic                       cmd_req,
    input  dm_geometry_pkg::glyph_t    cmd_glyph,
    input  logic                       cmd_hot,
    output logic                       cmd_ack,
    output dm_geometry_pkg::row_sel_t  row,
    output dm_geometry_pkg::col_bits_t col_green,
    output dm_geometry_pkg::col_bits_t col_red
);

    dm_geometry_pkg::glyph_t held_glyph;
    logic                    held_hot;
    logic                    pending;
    logic                    commit;

    dm_scan_if scan_slot ();

    dm_cmd_capture u_capture (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd_glyph  (cmd_glyph),
        .cmd_hot    (cmd_hot),
        .commit     (commit),
        .cmd_ack    (cmd_ack),
        .held_glyph (held_glyph),
        .held_hot   (held_hot),
        .pending    (pending)
    );

    dm_row_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .held_glyph (held_glyph),
        .held_hot   (held_hot),
        .pending    (pending),
        .commit     (commit),
        .slot       (scan_slot.scan)
    );

    dm_glyph_stage u_lookup (
        .clk        (clk),
        .rst        (rst),
        .slot       (scan_slot.lookup),
        .row        (row),
        .col_green  (col_green),
        .col_red    (col_red)
    );

endmodule

// ==== testbench/dm_matrix_tb.sv ====
`timescale 1ns/100ps

module dm_matrix_tb;
    import dm_geometry_pkg::*;

    localparam int ack_timeout   = 8;
    localparam int frame_timeout = 2 * dm_rows + 4;

    logic      clk;
    logic      rst;
    logic      enable;
    logic      cmd_req;
    glyph_t    cmd_glyph;
    logic      cmd_hot;
    logic      cmd_ack;
    row_sel_t  row;
    col_bits_t col_green;
    col_bits_t col_red;

    integer    errors;
    integer    checks;
    integer    seed;
    col_bits_t expected_rows [0:dm_rows-1] = '{default: '0};  // from the current pattern line
    col_bits_t old_rows [0:dm_rows-1] = '{default: '0};       // glyph shown before this line
    int        line_no      = 0;      // bumps as each line loads
    int        watched_line = 0;
    logic      saw_old      = 1'b0;
    logic      saw_new      = 1'b0;
    logic      last_en      = 1'b0;   // enable behind the outputs now showing
    integer    frame_errors = 0;

    dm_matrix_top UUT (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .cmd_req   (cmd_req),
        .cmd_glyph (cmd_glyph),
        .cmd_hot   (cmd_hot),
        .cmd_ack   (cmd_ack),
        .row       (row),
        .col_green (col_green),
        .col_red   (col_red)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors = errors + 1;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors = errors + 1;
    endtask

    function automatic logic rows_off_or_one_low(input row_sel_t r);
        return (r == '1) || ($countones(~r) == 1);
    endfunction

    // no glyph may show while idle
    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            checks = checks + 1;
            if (cmd_ack !== 1'b0)
                report_mismatch("cmd_ack", 8'h00, 8'(cmd_ack));
            if (rows_off_or_one_low(row) !== 1'b1)
                report_mismatch("row", 8'hff, row);
            if (col_green !== 8'h00)
                report_mismatch("col_green", 8'h00, col_green);
            if (col_red !== 8'h00)
                report_mismatch("col_red", 8'h00, col_red);
        end
    endtask

    task automatic send_command(input logic en, input glyph_t glyph, input logic hot);
        int waited;
        int hold;
        @(negedge clk);
        if (cmd_ack !== 1'b0)
            report_failure("cmd_ack was high before a request was made");
        @(posedge clk);
        enable    <= en;
        cmd_glyph <= glyph;
        cmd_hot   <= hot;
        cmd_req   <= 1'b1;
        @(negedge clk);
        if (cmd_ack !== 1'b0)
            report_failure("cmd_ack rose in the same cycle as cmd_req");
        waited = 0;
        while (cmd_ack !== 1'b1 && waited < ack_timeout)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (cmd_ack !== 1'b1)
            report_failure("no cmd_ack arrived within the timeout");
        else
        begin
            hold = $unsigned($random(seed)) % 3;  // req lingers, ack must hold
            repeat (hold)
            begin
                @(negedge clk);
                if (cmd_ack !== 1'b1)
                    report_mismatch("cmd_ack", 8'h01, 8'(cmd_ack));
            end
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (cmd_ack !== 1'b0 && waited < ack_timeout)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (cmd_ack !== 1'b0)
            report_failure("cmd_ack stayed high after cmd_req fell");
    endtask

    // one whole frame, row 0 through 7
    task automatic check_frame(input logic en, input logic hot);
        int        waited;
        row_sel_t  expected_row;
        col_bits_t green_exp;
        col_bits_t red_exp;
        waited = 0;
        @(negedge clk);
        while (row[0] !== 1'b0 && waited < frame_timeout)
        begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (row[0] !== 1'b0)
            report_failure("row 0 was not selected within the timeout");
        else
        begin
            for (int r = 0; r < dm_rows; r++)
            begin
                if (r > 0)
                    @(negedge clk);
                expected_row = ~(row_sel_t'(1) << r);
                green_exp    = en ? expected_rows[r] : '0;
                red_exp      = (en && hot) ? expected_rows[r] : '0;
                checks       = checks + 1;
                if (row !== expected_row)
                    report_mismatch("row", expected_row, row);
                if (col_green !== green_exp)
                    report_mismatch("col_green", green_exp, col_green);
                if (col_red !== red_exp)
                    report_mismatch("col_red", red_exp, col_red);
            end
        end
    endtask

    // a frame shows the old glyph or the new one and never rows of both
    always @(negedge clk)
    begin
        if (line_no != watched_line || row[0] === 1'b0)
        begin
            saw_old      = 1'b0;
            saw_new      = 1'b0;
            watched_line = line_no;
        end
        for (int r = 0; r < dm_rows; r++)
        begin
            if (row[r] === 1'b0 && last_en === 1'b1 && old_rows[r] !== expected_rows[r])
            begin
                saw_new = saw_new | (col_green === expected_rows[r]);
                saw_old = saw_old | (col_green === old_rows[r]);
            end
        end
        if (row[dm_rows-1] === 1'b0 && saw_old && saw_new)
        begin
            $display("Failure at %0t ns: a frame showed rows of two glyphs", $time);
            frame_errors = frame_errors + 1;
        end
        last_en = enable;
    end

    initial
    begin
        string      line;
        int         fd;
        int         fields;
        int         count;
        int         gap;
        logic [7:0] en_val;
        logic [7:0] glyph_val;
        logic [7:0] hot_val;
        logic       done;
        clk       = 1'b0;
        rst       = 1'b1;
        enable    = 1'b1;
        cmd_req   = 1'b0;
        cmd_glyph = '0;
        cmd_hot   = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 54;
        count     = 0;
        done      = 1'b0;

        check_idle(5);
        @(posedge clk);
        rst <= 1'b0;
        check_idle(2 * dm_rows);  // held glyph is blank until the first command

        fd = $fopen("testbench/dm_matrix_patterns.txt", "r");
        if (fd == 0)
            report_failure("cannot open testbench/dm_matrix_patterns.txt");
        else
        begin
            while (!done)
            begin
                if ($fgets(line, fd) == 0)
                    done = 1'b1;
                else if (line.len() >= 2 && line.getc(0) != "#")
                begin
                    @(posedge clk);
                    old_rows = expected_rows;
                    line_no  = line_no + 1;
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                     en_val, glyph_val, hot_val,
                                     expected_rows[0], expected_rows[1],
                                     expected_rows[2], expected_rows[3],
                                     expected_rows[4], expected_rows[5],
                                     expected_rows[6], expected_rows[7]);
                    if (fields != 11)
                        report_failure("a pattern line does not have eleven fields");
                    else
                    begin
                        send_command(en_val[0], glyph_val[3:0], hot_val[0]);
                        check_frame(en_val[0], hot_val[0]);
                        count = count + 1;
                        gap = $unsigned($random(seed)) % 4;
                        repeat (gap) @(posedge clk);
                    end
                end
            end
            $fclose(fd);
            if (count == 0)
                report_failure("the pattern file held no commands");
        end

        $display("%0d commands, %0d checks, %0d errors", count, checks,
                 errors + frame_errors);
        if (errors + frame_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== testbench/dm_matrix_patterns.txt ====
# enable glyph hot, then expected col_green for rows 0 to 7, all hex
# col_red expects the same bytes when hot is 1, else zero; enable 0 expects dark banks
1 0 0 00 00 18 3c 3c 18 00 00
1 1 1 00 00 38 7c 7c 38 00 00
1 2 0 00 00 3c 7e 7e 3c 00 00
1 3 1 00 3c 7e 7e 7e 7e 3c 00
1 4 0 3c 7e ff ff ff ff 7e 3c
1 5 1 ff ff ff ff ff ff ff ff
1 6 0 c3 e3 f1 e3 c7 e7 f7 fb
1 7 1 00 01 81 c3 83 c7 e7 f3
1 8 0 00 38 44 5a 4a 32 c4 38
1 9 1 00 00 60 fc 3f 3e 1c 00
1 a 0 00 00 18 3c 7e 7e 24 00
1 b 1 00 00 00 00 00 00 00 00
# glyphs past the table
1 c 0 00 00 00 00 00 00 00 00
1 d 1 00 00 00 00 00 00 00 00
1 e 0 00 00 00 00 00 00 00 00
1 f 1 00 00 00 00 00 00 00 00
# blanked, rows keep scanning
0 5 1 ff ff ff ff ff ff ff ff
0 4 0 3c 7e ff ff ff ff 7e 3c
1 5 1 ff ff ff ff ff ff ff ff
1 4 0 3c 7e ff ff ff ff 7e 3c
1 6 1 c3 e3 f1 e3 c7 e7 f7 fb
1 6 1 c3 e3 f1 e3 c7 e7 f7 fb
0 8 1 00 38 44 5a 4a 32 c4 38
1 8 1 00 38 44 5a 4a 32 c4 38
1 9 0 00 00 60 fc 3f 3e 1c 00
1 0 1 00 00 18 3c 3c 18 00 00
1 a 1 00 00 18 3c 7e 7e 24 00
1 7 0 00 01 81 c3 83 c7 e7 f3
1 3 0 00 3c 7e 7e 7e 7e 3c 00
1 2 1 00 00 3c 7e 7e 3c 00 00
1 1 0 00 00 38 7c 7c 38 00 00
1 c 1 00 00 00 00 00 00 00 00
1 5 0 ff ff ff ff ff ff ff ff
0 f 0 00 00 00 00 00 00 00 00
1 4 1 3c 7e ff ff ff ff 7e 3c
1 0 0 00 00 18 3c 3c 18 00 00

// ==== filelist.f ====
logic/dm_geometry_pkg.sv
logic/dm_glyph_pkg.sv
logic/dm_scan_if.sv
logic/dm_cmd_capture.sv
logic/dm_row_scan.sv
logic/dm_glyph_stage.sv
logic/dm_matrix_top.sv
testbench/dm_matrix_tb.sv

// ==== Makefile ====
# build and run the dot-matrix testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module dm_matrix_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vdm_matrix_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
